// File: armPipe.f
+incdir+logic
logic/armPipePkg.sv
logic/pipeReg.sv
logic/aluControl.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/armPipe.sv
testbench/armPipe_assertions.sv
testbench/armPipeTb.sv

// File: runSim.sh
#!/bin/sh
# Build the armPipe testbench with Verilator, run it and judge the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module armPipeTb \
  -f armPipe.f \
  -o armPipeSim

./obj_dir/armPipeSim | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log
then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1

// File: testbench/armPipeTb.sv
`timescale 1ns/10ps
`include "armPipe_macros.svh"

module armPipeTb;

  localparam int CLK_PERIOD = 100;
  localparam int ARITH_ITEMS = 60;
  localparam int UNKNOWN_ITEMS = 20;
  localparam int MEM_PAIRS = 40;
  localparam int BRANCH_ITEMS = 40;
  localparam int BURST_ITEMS = 80;
  localparam int TOTAL_ITEMS = ARITH_ITEMS + UNKNOWN_ITEMS + 2 * MEM_PAIRS + BRANCH_ITEMS
                               + BURST_ITEMS;
  localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 3 + 16 + 200;

  typedef struct packed {
    int unsigned        due;
    armPipePkg::wbT     wb;
    logic               pcSrc;
    logic [`DATA_W-1:0] branchAddress;
  } expectT;

  logic               clk = 1'b0;
  logic               rstN;
  logic               inValid;
  armPipePkg::idExT   inBundle;
  logic               wbValid;
  armPipePkg::wbT     wb;
  logic               pcSrc;
  logic [`DATA_W-1:0] branchAddress;

  expectT             expQ[$];
  expectT             seen;
  logic [`DATA_W-1:0] modelMem [`DMEM_DEPTH];
  int unsigned        negCount = 0;
  int                 errorCount = 0;
  int                 testErrorBase = 0;
  int                 testCount = 0;
  int                 checkedCount = 0;

  armPipe i_armPipe (
    .clk           (clk),
    .rstN          (rstN),
    .inValid       (inValid),
    .inBundle      (inBundle),
    .wbValid       (wbValid),
    .wb            (wb),
    .pcSrc         (pcSrc),
    .branchAddress (branchAddress)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  // the reference model runs in issue order so the memory sees stores and loads in sequence
  task automatic predictItem(input armPipePkg::idExT b, input int unsigned due);
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] res;
    logic [10:0]        opc;
    logic               zero;
    int                 idx;
    expectT             e;
    opc = b.instruction[31:21];
    if (b.aluSrc == armPipePkg::srcSignExt)
      opB = b.signExt;
    else if (b.aluSrc == armPipePkg::srcImm12)
      opB = {{(`DATA_W-12){1'b0}}, b.instruction[21:10]};
    else
      opB = b.data2;
    res = b.data1 + opB; // add covers memAddr, ADD, ADDI and every unknown opcode
    if (b.aluOp == armPipePkg::opPassB)
      res = opB;
    else if (b.aluOp == armPipePkg::opRegType && opc == `OP_SUB)
      res = b.data1 - opB;
    else if (b.aluOp == armPipePkg::opRegType && opc == `OP_AND)
      res = b.data1 & opB;
    else if (b.aluOp == armPipePkg::opRegType && opc == `OP_ORR)
      res = b.data1 | opB;
    else if (b.aluOp == armPipePkg::opImmType && opc[10:1] == `OP_SUBI)
      res = b.data1 - opB;
    zero = (res == '0);
    idx = int'((res >> 3) % 64'(`DMEM_DEPTH));
    e.due = due;
    e.pcSrc = b.ctrl.branch | (b.ctrl.branchZero & zero) | (b.ctrl.branchNotZero & ~zero);
    e.branchAddress = b.pc + b.signExt * 64'd4;
    e.wb.regWrite = b.ctrl.regWrite;
    e.wb.destReg = b.instruction[4:0];
    e.wb.writeData = b.ctrl.memToReg ? modelMem[idx] : res;
    if (b.ctrl.memWrite)
      modelMem[idx] = b.data2;
    expQ.push_back(e);
  endtask

  // the strobe shows at the next falling edge and its writeback three falling edges later
  task automatic sendItem(input armPipePkg::idExT b);
    @(posedge clk);
    inValid <= 1'b1;
    inBundle <= b;
    predictItem(b, negCount + 4);
  endtask

  task automatic idleCycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      inValid <= 1'b0;
    end
  endtask

  task automatic finishTest(input string name, input int items);
    idleCycles(1);
    while (expQ.size() != 0)
      @(posedge clk);
    testCount++;
    $display("test %s done, %0d items, %0d errors", name, items, errorCount - testErrorBase);
    testErrorBase = errorCount;
  endtask

  function automatic logic [`DATA_W-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [`DATA_W-1:0] randomOffset();
    return 64'($urandom_range(127, 0)); // two of these stay inside the 256-byte memory
  endfunction

  function automatic armPipePkg::aluSrcT randomSrc();
    return armPipePkg::aluSrcT'(2'($urandom_range(2, 0)));
  endfunction

  function automatic armPipePkg::idExT baseBundle();
    armPipePkg::idExT b;
    logic [15:0]      imm;
    imm = 16'($urandom);
    b.pc = rand64() & ~64'h3;
    b.instruction = $urandom;
    b.signExt = {{(`DATA_W-16){imm[15]}}, imm};
    b.data1 = rand64();
    b.data2 = rand64();
    b.aluSrc = armPipePkg::srcReg;
    b.aluOp = armPipePkg::opMemAddr;
    b.ctrl = '0;
    return b;
  endfunction

  function automatic armPipePkg::idExT arithBundle();
    armPipePkg::idExT b;
    int               sel;
    b = baseBundle();
    sel = $urandom_range(5, 0);
    case (sel)
      0: b.instruction[31:21] = `OP_ADD;
      1: b.instruction[31:21] = `OP_SUB;
      2: b.instruction[31:21] = `OP_AND;
      3: b.instruction[31:21] = `OP_ORR;
      4: b.instruction[31:22] = `OP_ADDI;
      default: b.instruction[31:22] = `OP_SUBI;
    endcase
    b.aluOp = (sel < 4) ? armPipePkg::opRegType : armPipePkg::opImmType;
    b.aluSrc = randomSrc();
    b.ctrl.regWrite = 1'b1;
    return b;
  endfunction

  function automatic armPipePkg::idExT unknownBundle();
    armPipePkg::idExT b;
    logic [10:0]      opc;
    b = baseBundle();
    do
    begin
      opc = 11'($urandom);
    end
    while (opc == `OP_ADD || opc == `OP_SUB || opc == `OP_AND || opc == `OP_ORR);
    b.instruction[31:21] = opc;
    b.aluOp = armPipePkg::opRegType;
    b.aluSrc = randomSrc();
    b.ctrl.regWrite = 1'b1;
    return b;
  endfunction

  function automatic armPipePkg::idExT branchBundle();
    armPipePkg::idExT b;
    int               kind;
    b = baseBundle();
    b.aluOp = armPipePkg::opPassB;
    if ($urandom_range(1, 0) == 0)
      b.data2 = '0; // half the compares see a zero register
    kind = $urandom_range(2, 0);
    case (kind)
      0: b.ctrl.branch = 1'b1;
      1: b.ctrl.branchZero = 1'b1;
      default: b.ctrl.branchNotZero = 1'b1;
    endcase
    return b;
  endfunction

  function automatic armPipePkg::idExT memBundle(input logic isStore,
                                                 input logic [`DATA_W-1:0] base,
                                                 input logic [`DATA_W-1:0] offset);
    armPipePkg::idExT b;
    b = baseBundle();
    b.data1 = base;
    b.signExt = offset;
    b.aluSrc = armPipePkg::srcSignExt;
    if (isStore)
    begin
      b.ctrl.memWrite = 1'b1;
    end
    else
    begin
      b.ctrl.memRead = 1'b1;
      b.ctrl.memToReg = 1'b1;
      b.ctrl.regWrite = 1'b1;
    end
    return b;
  endfunction

  always @(negedge clk)
  begin
    negCount = negCount + 1;
    if (expQ.size() != 0 && expQ[0].due == negCount)
    begin
      seen = expQ.pop_front();
      checkedCount++;
      checkValue("wbValid", 64'(1'b1), 64'(wbValid));
      checkValue("wb.regWrite", 64'(seen.wb.regWrite), 64'(wb.regWrite));
      checkValue("wb.destReg", 64'(seen.wb.destReg), 64'(wb.destReg));
      checkValue("wb.writeData", seen.wb.writeData, wb.writeData);
      checkValue("pcSrc", 64'(seen.pcSrc), 64'(pcSrc));
      checkValue("branchAddress", seen.branchAddress, branchAddress);
    end
    else
    begin
      checkValue("wbValid", 64'(1'b0), 64'(wbValid));
      checkValue("pcSrc", 64'(1'b0), 64'(pcSrc));
      checkValue("wb.regWrite", 64'(1'b0), 64'(wb.regWrite));
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    logic [`DATA_W-1:0] base;
    logic [`DATA_W-1:0] offset;
    int                 kind;
    rstN = 1'b0;
    inValid = 1'b0;
    inBundle = '0;
    void'($urandom(81084));
    for (int i = 0; i < `DMEM_DEPTH; i++)
      modelMem[i] = '0; // reset clears the data memory
    repeat (16) @(posedge clk);
    rstN <= 1'b1;

    repeat (ARITH_ITEMS) sendItem(arithBundle());
    finishTest("arithmetic", ARITH_ITEMS);

    repeat (UNKNOWN_ITEMS) sendItem(unknownBundle());
    finishTest("unknown opcode", UNKNOWN_ITEMS);

    repeat (MEM_PAIRS)
    begin
      base = randomOffset();
      offset = randomOffset();
      sendItem(memBundle(1'b1, base, offset));
      if ($urandom_range(1, 0) == 1)
        sendItem(memBundle(1'b0, base, offset)); // load right behind its store
      else
        sendItem(memBundle(1'b0, randomOffset(), randomOffset()));
    end
    finishTest("store and load", 2 * MEM_PAIRS);

    repeat (BRANCH_ITEMS) sendItem(branchBundle());
    finishTest("branch", BRANCH_ITEMS);

    repeat (BURST_ITEMS)
    begin
      kind = $urandom_range(3, 0);
      case (kind)
        0: sendItem(arithBundle());
        1: sendItem(branchBundle());
        2: sendItem(memBundle(1'b1, randomOffset(), randomOffset()));
        default: sendItem(memBundle(1'b0, randomOffset(), randomOffset()));
      endcase
      if ($urandom_range(1, 0) == 1)
        idleCycles($urandom_range(2, 1));
    end
    finishTest("throughput", BURST_ITEMS);

    $display("%0d tests, %0d items checked, %0d errors", testCount, checkedCount, errorCount);
    if (errorCount == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: testbench/armPipe_assertions.sv
`timescale 1ns/10ps

module armPipe_assertions (
  input logic clk,
  input logic rstN,
  input logic wbValid,
  input logic pcSrc,
  input logic regWrite
);

  // an item needs three edges to reach writeback, so the first three sampled edges stay quiet
  property quietAfterReset;
    @(posedge clk) (rstN && (!$past(rstN, 1) || !$past(rstN, 2) || !$past(rstN, 3)))
      |-> !(wbValid || pcSrc || regWrite);
  endproperty

  quietCheck: assert property (quietAfterReset)
    else $error("writeback output active within three cycles of reset release");

  redirectCheck: assert property (@(posedge clk) disable iff (!rstN) pcSrc |-> wbValid)
    else $error("pcSrc raised without wbValid");

  regWriteCheck: assert property (@(posedge clk) disable iff (!rstN) regWrite |-> wbValid)
    else $error("wb.regWrite raised without wbValid");

endmodule

bind armPipe armPipe_assertions i_armPipeAssertions (
  .clk      (clk),
  .rstN     (rstN),
  .wbValid  (wbValid),
  .pcSrc    (pcSrc),
  .regWrite (wb.regWrite)
);

// File: logic/armPipe.sv
`timescale 1ns/10ps
`include "armPipe_macros.svh"

module armPipe (
  input  logic               clk,
  input  logic               rstN,
  input  logic               inValid,
  input  armPipePkg::idExT   inBundle,
  output logic               wbValid,
  output armPipePkg::wbT     wb,
  output logic               pcSrc,
  output logic [`DATA_W-1:0] branchAddress
);

  logic              exValid;
  armPipePkg::idExT  exBundle;
  armPipePkg::exMemT exResult;
  logic              memValid;
  armPipePkg::exMemT memBundle;

  pipeReg #(.payloadT(armPipePkg::idExT)) i_idExReg (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inData   (inBundle),
    .outValid (exValid),
    .outData  (exBundle)
  );

  executeStage i_executeStage (
    .idEx  (exBundle),
    .exMem (exResult)
  );

  pipeReg #(.payloadT(armPipePkg::exMemT)) i_exMemReg (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (exValid),
    .inData   (exResult),
    .outValid (memValid),
    .outData  (memBundle)
  );

  memoryStage i_memoryStage (
    .clk           (clk),
    .rstN          (rstN),
    .inValid       (memValid),
    .exMem         (memBundle),
    .wbValid       (wbValid),
    .wb            (wb),
    .pcSrc         (pcSrc),
    .branchAddress (branchAddress)
  );

endmodule

// File: logic/memoryStage.sv
`timescale 1ns/10ps
`include "armPipe_macros.svh"

module memoryStage (
  input  logic               clk,
  input  logic               rstN,
  input  logic               inValid,
  input  armPipePkg::exMemT  exMem,
  output logic               wbValid,
  output armPipePkg::wbT     wb,
  output logic               pcSrc,
  output logic [`DATA_W-1:0] branchAddress
);

  localparam int ADDR_W = $clog2(`DMEM_DEPTH);

  logic [`DATA_W-1:0] dmem [`DMEM_DEPTH];
  logic [ADDR_W-1:0]  wordIdx;
  logic [`DATA_W-1:0] loadWord;
  logic [`DATA_W-1:0] writeData;
  logic               taken;
  logic               wbRegWrite;
  logic [4:0]         wbDestReg;
  logic [`DATA_W-1:0] wbWriteData;

  assign wordIdx  = exMem.result[ADDR_W+2:3]; // byte address, words are eight bytes
  assign loadWord = dmem[wordIdx];

  always_comb
  begin
    taken = exMem.ctrl.branch
         | (exMem.ctrl.branchZero & exMem.zero)
         | (exMem.ctrl.branchNotZero & ~exMem.zero);
  end

  assign writeData = exMem.ctrl.memToReg ? loadWord : exMem.result;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `DMEM_DEPTH; i++)
      begin
        dmem[i] <= '0; // loads before any store read back zero
      end
    end
    else if (inValid && exMem.ctrl.memWrite)
    begin
      dmem[wordIdx] <= exMem.storeData;
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      wbValid    <= 1'b0;
      wbRegWrite <= 1'b0;
      pcSrc      <= 1'b0;
    end
    else
    begin
      wbValid    <= inValid;
      wbRegWrite <= inValid & exMem.ctrl.regWrite;
      pcSrc      <= inValid & taken; // a one-cycle redirect pulse per taken branch
    end
  end

  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      wbDestReg     <= exMem.destReg;
      wbWriteData   <= writeData;
      branchAddress <= exMem.branchTarget;
    end
  end

  always_comb
  begin
    wb.regWrite  = wbRegWrite;
    wb.destReg   = wbDestReg;
    wb.writeData = wbWriteData;
  end

endmodule

// File: logic/executeStage.sv
`timescale 1ns/10ps
`include "armPipe_macros.svh"

module executeStage (
  input  armPipePkg::idExT  idEx,
  output armPipePkg::exMemT exMem
);

  armPipePkg::aluFuncT aluFunc;
  logic [`DATA_W-1:0]  operandB;
  logic [`DATA_W-1:0]  result;
  logic [`DATA_W-1:0]  branchTarget;

  aluControl i_aluControl (
    .aluOp   (idEx.aluOp),
    .opcode  (idEx.instruction[31:21]),
    .aluFunc (aluFunc)
  );

  always_comb
  begin
    case (idEx.aluSrc)
      armPipePkg::srcReg:
      begin
        operandB = idEx.data2;
      end
      armPipePkg::srcSignExt:
      begin
        operandB = idEx.signExt;
      end
      armPipePkg::srcImm12:
      begin
        operandB = {{(`DATA_W-12){1'b0}}, idEx.instruction[21:10]}; // unsigned 12-bit field
      end
      default:
      begin
        operandB = idEx.data2; // the unused encoding behaves like a register operand
      end
    endcase
  end

  always_comb
  begin
    case (aluFunc)
      armPipePkg::funcAnd:
      begin
        result = idEx.data1 & operandB;
      end
      armPipePkg::funcOr:
      begin
        result = idEx.data1 | operandB;
      end
      armPipePkg::funcSub:
      begin
        result = idEx.data1 - operandB;
      end
      armPipePkg::funcPassB:
      begin
        result = operandB; // zero then reflects data2 for CBZ and CBNZ
      end
      armPipePkg::funcNor:
      begin
        result = ~(idEx.data1 | operandB);
      end
      default:
      begin
        result = idEx.data1 + operandB;
      end
    endcase
  end

  // branch offsets count instructions, so scale by four bytes
  assign branchTarget = idEx.pc + (idEx.signExt << 2);

  always_comb
  begin
    exMem.destReg      = idEx.instruction[4:0];
    exMem.branchTarget = branchTarget;
    exMem.result       = result;
    exMem.storeData    = idEx.data2;
    exMem.zero         = (result == '0);
    exMem.ctrl         = idEx.ctrl;
  end

endmodule

// File: logic/aluControl.sv
`timescale 1ns/10ps
`include "armPipe_macros.svh"

module aluControl (
  input  armPipePkg::aluOpT   aluOp,
  input  logic [10:0]         opcode,
  output armPipePkg::aluFuncT aluFunc
);

  always_comb
  begin
    aluFunc = armPipePkg::funcAdd; // anything not decoded below falls back to add
    case (aluOp)
      armPipePkg::opMemAddr:
      begin
        aluFunc = armPipePkg::funcAdd;
      end
      armPipePkg::opPassB:
      begin
        aluFunc = armPipePkg::funcPassB;
      end
      armPipePkg::opRegType:
      begin
        case (opcode)
          `OP_ADD: aluFunc = armPipePkg::funcAdd;
          `OP_SUB: aluFunc = armPipePkg::funcSub;
          `OP_AND: aluFunc = armPipePkg::funcAnd;
          `OP_ORR: aluFunc = armPipePkg::funcOr;
          default: aluFunc = armPipePkg::funcAdd;
        endcase
      end
      armPipePkg::opImmType:
      begin
        // the immediate forms only define the upper ten bits
        case (opcode[10:1])
          `OP_ADDI: aluFunc = armPipePkg::funcAdd;
          `OP_SUBI: aluFunc = armPipePkg::funcSub;
          default:  aluFunc = armPipePkg::funcAdd;
        endcase
      end
      default:
      begin
        aluFunc = armPipePkg::funcAdd;
      end
    endcase
  end

endmodule

// File: logic/pipeReg.sv
`timescale 1ns/10ps

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    inValid,
  input  payloadT inData,
  output logic    outValid,
  output payloadT outData
);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= inValid; // no back-pressure so the stage always advances
    end
  end

  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      outData <= inData; // idle cycles keep the last bundle
    end
  end

endmodule

// File: logic/armPipePkg.sv
`include "armPipe_macros.svh"

package armPipePkg;

  typedef enum logic [1:0] {
    opMemAddr = 2'b00, // address calculation for loads and stores
    opPassB   = 2'b01, // compare-and-branch looks at the second operand only
    opRegType = 2'b10,
    opImmType = 2'b11
  } aluOpT;

  typedef enum logic [1:0] {
    srcReg     = 2'b00,
    srcSignExt = 2'b01,
    srcImm12   = 2'b10
  } aluSrcT;

  typedef enum logic [3:0] {
    funcAnd   = 4'b0000,
    funcOr    = 4'b0001,
    funcAdd   = 4'b0010,
    funcSub   = 4'b0110,
    funcPassB = 4'b0111,
    funcNor   = 4'b1100
  } aluFuncT;

  typedef struct packed {
    logic branch;
    logic branchZero;
    logic branchNotZero;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;
  } ctrlT;

  typedef struct packed {
    logic [`DATA_W-1:0] pc;
    logic [31:0]        instruction;
    logic [`DATA_W-1:0] signExt;
    logic [`DATA_W-1:0] data1;
    logic [`DATA_W-1:0] data2;
    aluSrcT             aluSrc;
    aluOpT              aluOp;
    ctrlT               ctrl;
  } idExT;

  typedef struct packed {
    logic [4:0]         destReg;
    logic [`DATA_W-1:0] branchTarget;
    logic [`DATA_W-1:0] result;
    logic [`DATA_W-1:0] storeData;
    logic               zero;
    ctrlT               ctrl;
  } exMemT;

  typedef struct packed {
    logic               regWrite;
    logic [4:0]         destReg;
    logic [`DATA_W-1:0] writeData;
  } wbT;

endpackage

// File: logic/armPipe_macros.svh
`ifndef ARMPIPE_MACROS_SVH
`define ARMPIPE_MACROS_SVH

// datapath width of the whole slice
`define DATA_W 64

// 64-bit words held in the data memory
`define DMEM_DEPTH 32

// R-format opcodes, instruction bits 31 to 21
`define OP_ADD 11'b10001011000
`define OP_SUB 11'b11001011000
`define OP_AND 11'b10001010000
`define OP_ORR 11'b10101010000

// I-format opcodes are only 10 bits wide, bits 31 to 22
`define OP_ADDI 10'b1001000100
`define OP_SUBI 10'b1101000100

`endif
